// File: hdl/cursor_config.svh
`ifndef CURSOR_CONFIG_SVH
`define CURSOR_CONFIG_SVH

// framebuffer geometry
`define FB_W 16
`define FB_H 16
`define COORD_W 4

// outline square, corner to corner
`define CURSOR_SIDE 4

// dwell lengths in clock cycles
`define DWELL_WHITE 12
`define DWELL_BLACK 8
`define DWELL_W 8

`define PIX_WHITE 8'd255
`define PIX_BLACK 8'd0

`endif

// File: hdl/cursor_pkg.sv
`default_nettype none

`include "cursor_config.svh"

package cursor_pkg;

  typedef struct packed {
    logic [`COORD_W-1:0] x;
    logic [`COORD_W-1:0] y;
  } coord_t;

  typedef logic [7:0] pixel_t;

  // one framebuffer write
  typedef struct packed {
    logic   valid;
    coord_t addr;
    pixel_t data;
  } pix_wr_t;

  typedef enum logic [1:0] {
    DIR_RIGHT,
    DIR_DOWN,
    DIR_LEFT,
    DIR_UP
  } dir_e;

  typedef struct packed {
    logic load_origin;
    logic step_clear;
    logic paint;
    dir_e dir;
    logic colour_black;
    logic dwell_start;
  } cursor_cmd_t;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_PAINT,
    ST_CHECK,
    ST_SIDE_CLR,
    ST_DWELL,
    ST_DONE
  } cursor_state_e;

endpackage

`default_nettype wire

// File: hdl/cursor_blink_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cursor_blink_ctrl (
  input  wire  logic                    clk,
  input  wire  logic                    rst,
  input  wire  logic                    start,
  input  wire  logic                    side_end,
  input  wire  logic                    dwell_end,
  output cursor_pkg::cursor_cmd_t       cmd,
  output logic                          busy,
  output logic                          done,
  output cursor_pkg::cursor_state_e     state
);

  import cursor_pkg::*;

  // white, black, white, black
  localparam logic [1:0] LAST_PASS = 2'd3;

  logic [1:0] pass_q;
  dir_e       dir_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_IDLE;
      pass_q <= 2'd0;
      dir_q  <= DIR_RIGHT;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state  <= ST_PAINT;
            pass_q <= 2'd0;
            dir_q  <= DIR_RIGHT;
          end
        end

        ST_PAINT: begin
          state <= ST_CHECK;
        end

        ST_CHECK: begin
          // step count settles during this cycle
          state <= side_end ? ST_SIDE_CLR : ST_PAINT;
        end

        ST_SIDE_CLR: begin
          if (dir_q == DIR_UP) begin
            state <= ST_DWELL; // outline closed, timer armed this cycle
          end else begin
            dir_q <= dir_e'(dir_q + 2'd1);
            state <= ST_PAINT;
          end
        end

        ST_DWELL: begin
          if (dwell_end) begin
            if (pass_q == LAST_PASS) begin
              state <= ST_DONE;
            end else begin
              pass_q <= pass_q + 2'd1;
              dir_q  <= DIR_RIGHT; // walker is back on the origin
              state  <= ST_PAINT;
            end
          end
        end

        ST_DONE: begin
          state <= ST_IDLE;
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_comb begin
    cmd              = '0;
    cmd.dir          = dir_q;
    cmd.colour_black = pass_q[0]; // odd passes erase
    case (state)
      ST_IDLE: begin
        cmd.load_origin = start;
      end
      ST_PAINT: begin
        cmd.paint = 1'b1;
      end
      ST_SIDE_CLR: begin
        cmd.step_clear  = 1'b1;
        cmd.dwell_start = (dir_q == DIR_UP);
      end
      default: begin
      end
    endcase
  end

  assign busy = (state != ST_IDLE);
  assign done = (state == ST_DONE);

endmodule

`default_nettype wire

// File: hdl/cursor_walker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cursor_config.svh"

module cursor_walker (
  input  wire  logic                    clk,
  input  wire  logic                    rst,
  input  wire  cursor_pkg::cursor_cmd_t cmd,
  input  wire  cursor_pkg::coord_t      origin,
  output logic                          side_end,
  output cursor_pkg::pix_wr_t           wr
);

  import cursor_pkg::*;

  localparam int STEP_W = $clog2(`CURSOR_SIDE);
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`CURSOR_SIDE - 1);
  localparam logic [`COORD_W-1:0] X_MAX = `COORD_W'(`FB_W - 1);
  localparam logic [`COORD_W-1:0] Y_MAX = `COORD_W'(`FB_H - 1);

  coord_t             pos;
  coord_t             next_pos;
  logic [STEP_W-1:0]  step_cnt;
  logic               wr_valid;
  coord_t             wr_addr;
  pixel_t             wr_data;

  // one pixel move with wrap at the framebuffer edges
  always_comb begin
    next_pos = pos;
    case (cmd.dir)
      DIR_RIGHT: next_pos.x = (pos.x == X_MAX) ? '0 : pos.x + 1'b1;
      DIR_DOWN:  next_pos.y = (pos.y == Y_MAX) ? '0 : pos.y + 1'b1;
      DIR_LEFT:  next_pos.x = (pos.x == '0) ? X_MAX : pos.x - 1'b1;
      DIR_UP:    next_pos.y = (pos.y == '0) ? Y_MAX : pos.y - 1'b1;
      default:   next_pos = pos;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      step_cnt <= '0;
      wr_valid <= 1'b0;
    end else begin
      if (cmd.step_clear || cmd.load_origin) begin
        step_cnt <= '0;
      end else if (cmd.paint) begin
        step_cnt <= step_cnt + 1'b1;
      end
      wr_valid <= cmd.paint;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.load_origin) begin
      pos <= origin;
    end else if (cmd.paint) begin
      pos <= next_pos;
    end
    if (cmd.paint) begin
      wr_addr <= pos; // write the pixel we stand on, then move
      wr_data <= cmd.colour_black ? `PIX_BLACK : `PIX_WHITE;
    end
  end

  assign side_end = (step_cnt == LAST_STEP);
  assign wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// File: hdl/dwell_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cursor_config.svh"

module dwell_timer (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic dwell_start,
  input  wire logic colour_black,
  output logic      dwell_end
);

  localparam logic [`DWELL_W-1:0] LOAD_WHITE = `DWELL_W'(`DWELL_WHITE - 1);
  localparam logic [`DWELL_W-1:0] LOAD_BLACK = `DWELL_W'(`DWELL_BLACK - 1);

  logic [`DWELL_W-1:0] cnt;
  logic                running;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt     <= '0;
      running <= 1'b0;
    end else if (dwell_start) begin
      // restart even when a dwell is already running
      cnt     <= colour_black ? LOAD_BLACK : LOAD_WHITE;
      running <= 1'b1;
    end else if (running) begin
      if (cnt == '0) begin
        running <= 1'b0;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  assign dwell_end = running && (cnt == '0); // single cycle, running drops next edge

endmodule

`default_nettype wire

// File: hdl/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cursor_config.svh"

module frame_buffer (
  input  wire  logic                clk,
  input  wire  cursor_pkg::pix_wr_t wr,
  input  wire  cursor_pkg::coord_t  rd_addr,
  output cursor_pkg::pixel_t        rd_data
);

  import cursor_pkg::*;

  // row major, mem[y][x]
  pixel_t mem [`FB_H][`FB_W];

  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr.addr.y][wr.addr.x] <= wr.data;
    end
  end

  // registered read, old data on a same-cycle write
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr.y][rd_addr.x];
  end

endmodule

`default_nettype wire

// File: hdl/palette_cursor_top.sv
`timescale 1ns/1ps
`default_nettype none

module palette_cursor_top (
  input  wire  logic                clk,
  input  wire  logic                rst,
  input  wire  logic                start,
  input  wire  cursor_pkg::coord_t  origin,
  input  wire  cursor_pkg::pix_wr_t host_wr,
  input  wire  cursor_pkg::coord_t  rd_addr,
  output logic                      busy,
  output logic                      done,
  output cursor_pkg::pix_wr_t       cursor_wr,
  output cursor_pkg::pixel_t        rd_data
);

  import cursor_pkg::*;

  cursor_cmd_t cmd;
  logic        side_end;
  logic        dwell_end;
  pix_wr_t     fb_wr;

  cursor_blink_ctrl ctrl0 (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .side_end  (side_end),
    .dwell_end (dwell_end),
    .cmd       (cmd),
    .busy      (busy),
    .done      (done),
    .state     ()
  );

  cursor_walker walker0 (
    .clk      (clk),
    .rst      (rst),
    .cmd      (cmd),
    .origin   (origin),
    .side_end (side_end),
    .wr       (cursor_wr)
  );

  dwell_timer timer0 (
    .clk          (clk),
    .rst          (rst),
    .dwell_start  (cmd.dwell_start),
    .colour_black (cmd.colour_black),
    .dwell_end    (dwell_end)
  );

  // cursor owns the write port for the whole run, host writes fall on the floor
  assign fb_wr = busy ? cursor_wr : host_wr;

  frame_buffer fb0 (
    .clk     (clk),
    .wr      (fb_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// File: verif/palette_cursor_checker.sv
`timescale 1ns/1ps
`default_nettype none

module palette_cursor_checker (
  input wire logic                      clk,
  input wire logic                      rst,
  input wire cursor_pkg::cursor_state_e state,
  input wire cursor_pkg::cursor_cmd_t   cmd,
  input wire logic                      busy,
  input wire logic                      done
);

  import cursor_pkg::*;

  int assert_fails = 0; // read back by the testbench at the end

  done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      $error("done stayed high for more than one cycle");
      assert_fails++;
    end

  // done only comes out of the last dwell
  done_after_dwell: assert property (@(posedge clk) disable iff (rst)
    done |-> $past(state) == ST_DWELL)
    else begin
      $error("done did not follow the dwell state");
      assert_fails++;
    end

  idle_not_busy: assert property (@(posedge clk) disable iff (rst)
    state == ST_IDLE |-> !busy)
    else begin
      $error("busy high while idle");
      assert_fails++;
    end

  no_paint_in_dwell: assert property (@(posedge clk) disable iff (rst)
    state == ST_DWELL |-> !cmd.paint)
    else begin
      $error("paint issued during dwell");
      assert_fails++;
    end

endmodule

`default_nettype wire

// File: verif/palette_cursor_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cursor_config.svh"

module palette_cursor_tb;

  import cursor_pkg::*;

  localparam int NUM_RUNS        = 5;
  localparam int WRITES_PER_PASS = 4 * (`CURSOR_SIDE - 1);
  localparam int WRITES_PER_RUN  = 4 * WRITES_PER_PASS;
  localparam int PIXELS          = `FB_W * `FB_H;
  localparam int RUN_CYCLES      = 4 * (2 * WRITES_PER_PASS + 4)
                                   + 2 * (`DWELL_WHITE + `DWELL_BLACK) + 32;
  // fill takes one cycle per pixel and readback two
  localparam int PER_RUN_CYCLES  = RUN_CYCLES + 3 * PIXELS + 100;
  localparam int TIMEOUT_CYCLES  = 16 + NUM_RUNS * PER_RUN_CYCLES + 50;

  logic    clk = 1'b0;
  logic    rst;
  logic    start;
  coord_t  origin;
  pix_wr_t host_wr;
  coord_t  rd_addr;
  logic    busy;
  logic    done;
  pix_wr_t cursor_wr;
  pixel_t  rd_data;

  int     errors = 0;
  int     cycle = 0;
  int     wr_idx = 0;
  int     last_wr_cycle = 0;
  bit     run_active = 1'b0;
  coord_t exp_origin;
  pixel_t model [`FB_H][`FB_W]; // expected framebuffer contents indexed [y][x]

  palette_cursor_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .origin    (origin),
    .host_wr   (host_wr),
    .rd_addr   (rd_addr),
    .busy      (busy),
    .done      (done),
    .cursor_wr (cursor_wr),
    .rd_data   (rd_data)
  );

  bind cursor_blink_ctrl palette_cursor_checker chk0 (
    .clk   (clk),
    .rst   (rst),
    .state (state),
    .cmd   (cmd),
    .busy  (busy),
    .done  (done)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: no finish after %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_value(input int got, input int expected, input string what);
    if (got !== expected) begin
      errors++;
      $display("FAILED at %0t ns: %s, got %0d expected %0d", $time, what, got, expected);
    end
  endtask

  // position of the k-th outline write after side-1 steps right, down, left and up
  function automatic coord_t expected_outline(input coord_t org, input int k);
    coord_t p;
    int     side;
    p = org;
    for (int i = 0; i < k; i++) begin
      side = i / (`CURSOR_SIDE - 1);
      case (side)
        0:       p.x = `COORD_W'((int'(p.x) + 1) % `FB_W);
        1:       p.y = `COORD_W'((int'(p.y) + 1) % `FB_H);
        2:       p.x = `COORD_W'((int'(p.x) + `FB_W - 1) % `FB_W);
        default: p.y = `COORD_W'((int'(p.y) + `FB_H - 1) % `FB_H);
      endcase
    end
    return p;
  endfunction

  function automatic int expected_colour(input int pass_no);
    return (pass_no % 2 == 1) ? int'(`PIX_BLACK) : int'(`PIX_WHITE);
  endfunction

  function automatic int dwell_of(input int pass_no);
    return (pass_no % 2 == 1) ? `DWELL_BLACK : `DWELL_WHITE;
  endfunction

  always @(negedge clk) begin : write_monitor
    coord_t exp_pos;
    int     pass_no;
    int     k;
    if (!rst && cursor_wr.valid) begin
      check_value(int'(run_active && wr_idx < WRITES_PER_RUN), 1, "cursor write inside a run");
      pass_no = wr_idx / WRITES_PER_PASS;
      k       = wr_idx % WRITES_PER_PASS;
      exp_pos = expected_outline(exp_origin, k);
      check_value(int'(cursor_wr.addr.x), int'(exp_pos.x), $sformatf("write %0d x", wr_idx));
      check_value(int'(cursor_wr.addr.y), int'(exp_pos.y), $sformatf("write %0d y", wr_idx));
      check_value(int'(cursor_wr.data), expected_colour(pass_no),
                  $sformatf("write %0d colour", wr_idx));
      if (k == 0 && pass_no > 0) begin
        check_value(int'(cycle - last_wr_cycle >= dwell_of(pass_no - 1)), 1,
                    $sformatf("gap of %0d cycles before pass %0d", cycle - last_wr_cycle, pass_no));
      end
      wr_idx++;
      last_wr_cycle = cycle;
    end
  end

  task automatic fill_frame();
    pix_wr_t w;
    for (int y = 0; y < `FB_H; y++) begin
      for (int x = 0; x < `FB_W; x++) begin
        w.valid  = 1'b1;
        w.addr.x = `COORD_W'(x);
        w.addr.y = `COORD_W'(y);
        w.data   = pixel_t'($urandom) ^ {w.addr.y, w.addr.x};
        @(posedge clk);
        host_wr <= w;
        model[y][x] = w.data;
      end
    end
    @(posedge clk);
    host_wr <= '0;
  endtask

  task automatic start_run(input coord_t o);
    @(posedge clk);
    start      <= 1'b1;
    origin     <= o;
    exp_origin = o;
    wr_idx     = 0;
    run_active = 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // none of these host writes or the second start may land while busy
  task automatic poke_while_busy(input coord_t o);
    pix_wr_t w;
    coord_t  other;
    @(negedge clk);
    check_value(int'(busy), 1, "busy during run");
    w.valid  = 1'b1;
    w.addr.x = o.x + 4'd1; // inside the square
    w.addr.y = o.y + 4'd1;
    w.data   = ~model[w.addr.y][w.addr.x];
    @(posedge clk);
    host_wr <= w;
    w.addr.x = o.x + 4'd8; // well away from the outline
    w.addr.y = o.y + 4'd8;
    w.data   = ~model[w.addr.y][w.addr.x];
    @(posedge clk);
    host_wr <= w;
    other.x = o.x + 4'd5;
    other.y = o.y + 4'd5;
    @(posedge clk);
    host_wr <= '0;
    start   <= 1'b1;
    origin  <= other;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_done();
    do begin
      @(negedge clk);
    end while (done !== 1'b1);
    check_value(wr_idx, WRITES_PER_RUN, "cursor writes per run");
    run_active = 1'b0;
    @(negedge clk);
    check_value(int'(busy), 0, "busy after done");
  endtask

  task automatic read_back();
    coord_t a;
    for (int y = 0; y < `FB_H; y++) begin
      for (int x = 0; x < `FB_W; x++) begin
        a.x = `COORD_W'(x);
        a.y = `COORD_W'(y);
        @(posedge clk);
        rd_addr <= a;
        @(posedge clk);
        @(negedge clk);
        check_value(int'(rd_data), int'(model[y][x]), $sformatf("readback (%0d,%0d)", x, y));
      end
    end
  endtask

  initial begin
    coord_t o;
    coord_t p;
    int     delay;
    void'($urandom(5));
    rst     = 1'b1;
    start   = 1'b0;
    origin  = '0;
    host_wr = '0;
    rd_addr = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    for (int run = 0; run < NUM_RUNS; run++) begin
      if (run == 0) begin
        o.x = 4'd14; // wraps right and down
        o.y = 4'd15;
      end else if (run == 1) begin
        o.x = 4'd1;
        o.y = 4'd14;
      end else begin
        o.x = `COORD_W'($urandom);
        o.y = `COORD_W'($urandom);
      end
      fill_frame();
      start_run(o);
      delay = 3 + int'($urandom % 40);
      repeat (delay) @(posedge clk);
      poke_while_busy(o);
      wait_done();
      // last pass leaves the outline black
      for (int k = 0; k < WRITES_PER_PASS; k++) begin
        p = expected_outline(o, k);
        model[p.y][p.x] = `PIX_BLACK;
      end
      read_back();
    end

    repeat (4) @(posedge clk);
    $display("closing: %0d check errors, %0d assertion failures",
             errors, dut0.ctrl0.chk0.assert_fails);
    if (errors == 0 && dut0.ctrl0.chk0.assert_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
hdl/cursor_pkg.sv
hdl/cursor_blink_ctrl.sv
hdl/cursor_walker.sv
hdl/dwell_timer.sv
hdl/frame_buffer.sv
hdl/palette_cursor_top.sv
verif/palette_cursor_checker.sv
verif/palette_cursor_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= palette_cursor_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
